// File: mips_defines.svh
// Width and count macros for the MIPS32 writeback back end; include wherever a width is needed.
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data word width.
`define DATA_W 32

// general register count and index width.
`define REG_NUM 32
`define REG_AW 5

// alu opcode width.
`define ALUOP_W 8

`endif

// File: cpu_types_pkg.sv
// Vector types for words, addresses and register indices, imported by the writeback RTL.
`include "mips_defines.svh"

package cpu_types_pkg;

    // one data word.
    typedef logic [`DATA_W-1:0] word_t;

    // virtual address as wide as a word on MIPS32.
    typedef logic [`DATA_W-1:0] addr_t;

    // general register index.
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // hi in the upper half, lo in the lower half.
    typedef logic [2*`DATA_W-1:0] dword_t;

endpackage

// File: alu_op_pkg.sv
// ALU opcode type and the opcode values seen by writeback; import to decode loads.
`include "mips_defines.svh"

package alu_op_pkg;

    typedef logic [`ALUOP_W-1:0] alu_op_t;

    localparam alu_op_t ALU_NOP = 8'h00;
    // stands for every op whose result comes from the alu.
    localparam alu_op_t ALU_ADD = 8'h01;
    localparam alu_op_t ALU_SW  = 8'h3c;

    // loads.
    localparam alu_op_t ALU_LB  = 8'h30;
    localparam alu_op_t ALU_LBU = 8'h31;
    localparam alu_op_t ALU_LH  = 8'h32;
    localparam alu_op_t ALU_LHU = 8'h33;
    localparam alu_op_t ALU_LW  = 8'h34;
    localparam alu_op_t ALU_LWL = 8'h35;
    localparam alu_op_t ALU_LWR = 8'h36;

    // true when the register result comes from memory data.
    function automatic logic is_load(alu_op_t op);
        return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR};
    endfunction

endpackage

// File: wb_if.sv
// Interfaces for the MEM/WB record and the register commit write inside the writeback top.
`timescale 1ns/10ps

interface wb_stage_if;
    import cpu_types_pkg::*;
    import alu_op_pkg::*;

    addr_t     pc;
    alu_op_t   aluop;
    word_t     alures;
    // old destination value that lwl and lwr merge into.
    word_t     opr2;
    addr_t     m_vaddr;
    word_t     m_rdata;
    logic      wreg;
    reg_addr_t wraddr;
    logic      whilo;
    dword_t    hilo;

    modport src (output pc, aluop, alures, opr2, m_vaddr, m_rdata,
                 output wreg, wraddr, whilo, hilo);
    modport dst (input pc, aluop, alures, opr2, m_vaddr, m_rdata,
                 input wreg, wraddr, whilo, hilo);
endinterface

interface rf_write_if;
    import cpu_types_pkg::*;

    logic      wen;
    reg_addr_t waddr;
    word_t     wdata;
    logic      whilo;
    dword_t    hilo;

    modport src (output wen, waddr, wdata, whilo, hilo);
    modport dst (input wen, waddr, wdata, whilo, hilo);
endinterface

// File: mem_wb_reg.sv
// MEM/WB pipeline register; captures the memory-stage record, holds on stall, bubbles on flush.
`timescale 1ns/10ps

module mem_wb_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    input  cpu_types_pkg::addr_t     mem_pc,
    input  alu_op_pkg::alu_op_t      mem_aluop,
    input  cpu_types_pkg::word_t     mem_alures,
    input  cpu_types_pkg::word_t     mem_opr2,
    input  cpu_types_pkg::addr_t     mem_m_vaddr,
    input  cpu_types_pkg::word_t     mem_m_rdata,
    input  logic                  mem_wreg,
    input  cpu_types_pkg::reg_addr_t mem_wraddr,
    input  logic                  mem_whilo,
    input  cpu_types_pkg::dword_t    mem_hilo,
    wb_stage_if.src               wb
);
    import alu_op_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb.pc      <= '0;
            wb.aluop   <= ALU_NOP;
            wb.alures  <= '0;
            wb.opr2    <= '0;
            wb.m_vaddr <= '0;
            wb.m_rdata <= '0;
            wb.wreg    <= 1'b0;
            wb.wraddr  <= '0;
            wb.whilo   <= 1'b0;
            wb.hilo    <= '0;
        end else if (flush) begin
            // flush beats stall.
            wb.pc      <= '0;
            wb.aluop   <= ALU_NOP;
            wb.alures  <= '0;
            wb.opr2    <= '0;
            wb.m_vaddr <= '0;
            wb.m_rdata <= '0;
            wb.wreg    <= 1'b0;
            wb.wraddr  <= '0;
            wb.whilo   <= 1'b0;
            wb.hilo    <= '0;
        end else if (!stall) begin
            wb.pc      <= mem_pc;
            wb.aluop   <= mem_aluop;
            wb.alures  <= mem_alures;
            wb.opr2    <= mem_opr2;
            wb.m_vaddr <= mem_m_vaddr;
            wb.m_rdata <= mem_m_rdata;
            wb.wreg    <= mem_wreg;
            wb.wraddr  <= mem_wraddr;
            wb.whilo   <= mem_whilo;
            wb.hilo    <= mem_hilo;
        end
    end

    // a flushed record must not reach the register file.
    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!wb.wreg && !wb.whilo))
        else $error("write enable set after flush");

    a_no_x: assert property (@(posedge clk) !rst |->
        !$isunknown({wb.pc, wb.aluop, wb.alures, wb.opr2, wb.m_vaddr,
                     wb.m_rdata, wb.wreg, wb.wraddr, wb.whilo, wb.hilo}))
        else $error("unknown field in MEM/WB record");

endmodule

// File: wb_load_align.sv
// Writeback datapath; picks the alu result or the aligned load data and forms the commit write.
`timescale 1ns/10ps

module wb_load_align (
    wb_stage_if.dst wb,
    rf_write_if.src cm
);
    import cpu_types_pkg::*;
    import alu_op_pkg::*;

    logic [1:0]  off;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       ld_data;

    // memory data is little-endian.
    assign off     = wb.m_vaddr[1:0];
    assign ld_byte = wb.m_rdata[{off, 3'b000} +: 8];
    assign ld_half = off[1] ? wb.m_rdata[31:16] : wb.m_rdata[15:0];

    always_comb begin
        case (wb.aluop)
            ALU_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            ALU_LBU: ld_data = {24'h000000, ld_byte};
            ALU_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
            ALU_LHU: ld_data = {16'h0000, ld_half};
            // lwl fills the register from the top down.
            ALU_LWL: begin
                case (off)
                    2'd0:    ld_data = {wb.m_rdata[7:0], wb.opr2[23:0]};
                    2'd1:    ld_data = {wb.m_rdata[15:0], wb.opr2[15:0]};
                    2'd2:    ld_data = {wb.m_rdata[23:0], wb.opr2[7:0]};
                    default: ld_data = wb.m_rdata;
                endcase
            end
            // lwr fills it from the bottom up.
            ALU_LWR: begin
                case (off)
                    2'd0:    ld_data = wb.m_rdata;
                    2'd1:    ld_data = {wb.opr2[31:24], wb.m_rdata[31:8]};
                    2'd2:    ld_data = {wb.opr2[31:16], wb.m_rdata[31:16]};
                    default: ld_data = {wb.opr2[31:8], wb.m_rdata[31:24]};
                endcase
            end
            default: ld_data = wb.m_rdata;
        endcase
    end

    assign cm.wdata = is_load(wb.aluop) ? ld_data : wb.alures;
    assign cm.wen   = wb.wreg;
    assign cm.waddr = wb.wraddr;
    assign cm.whilo = wb.whilo;
    assign cm.hilo  = wb.hilo;

    // address errors are caught before writeback.
    always_comb begin
        if (wb.aluop == ALU_LH || wb.aluop == ALU_LHU) begin
            a_half_aligned: assert (!wb.m_vaddr[0])
                else $error("halfword load at odd address %h", wb.m_vaddr);
        end
    end

endmodule

// File: reg_file_hilo.sv
// General register file with HI/LO; commits the writeback result and exposes one read port.
`timescale 1ns/10ps
`include "mips_defines.svh"

module reg_file_hilo (
    input  logic                     clk,
    input  logic                     rst,
    rf_write_if.dst                  cm,
    input  cpu_types_pkg::reg_addr_t rd_addr,
    output cpu_types_pkg::word_t     rd_data,
    output cpu_types_pkg::word_t     hi,
    output cpu_types_pkg::word_t     lo
);
    import cpu_types_pkg::*;

    // register 0 has no storage.
    word_t gpr [1:`REG_NUM-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                gpr[i] <= '0;
            end
        end else if (cm.wen && cm.waddr != '0) begin
            gpr[cm.waddr] <= cm.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (cm.whilo) begin
            hi <= cm.hilo[2*`DATA_W-1:`DATA_W];
            lo <= cm.hilo[`DATA_W-1:0];
        end
    end

    // no bypass of the write in flight.
    assign rd_data = (rd_addr == '0) ? '0 : gpr[rd_addr];

    a_zero_reg: assert property (@(posedge clk) disable iff (rst)
        (rd_addr == '0) |-> (rd_data == '0))
        else $error("register 0 reads %h", rd_data);

endmodule

// File: mem_wb_top.sv
// Writeback back-end top; MEM/WB register, load alignment and register file behind plain ports.
`timescale 1ns/10ps

module mem_wb_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     flush,
    input  cpu_types_pkg::addr_t     mem_pc,
    input  alu_op_pkg::alu_op_t      mem_aluop,
    input  cpu_types_pkg::word_t     mem_alures,
    input  cpu_types_pkg::word_t     mem_opr2,
    input  cpu_types_pkg::addr_t     mem_m_vaddr,
    input  cpu_types_pkg::word_t     mem_m_rdata,
    input  logic                     mem_wreg,
    input  cpu_types_pkg::reg_addr_t mem_wraddr,
    input  logic                     mem_whilo,
    input  cpu_types_pkg::dword_t    mem_hilo,
    output cpu_types_pkg::addr_t     wb_pc,
    input  cpu_types_pkg::reg_addr_t rd_addr,
    output cpu_types_pkg::word_t     rd_data,
    output cpu_types_pkg::word_t     hi,
    output cpu_types_pkg::word_t     lo
);

    wb_stage_if wb_bus ();
    rf_write_if cm_bus ();

    mem_wb_reg u_mem_wb_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .mem_pc      (mem_pc),
        .mem_aluop   (mem_aluop),
        .mem_alures  (mem_alures),
        .mem_opr2    (mem_opr2),
        .mem_m_vaddr (mem_m_vaddr),
        .mem_m_rdata (mem_m_rdata),
        .mem_wreg    (mem_wreg),
        .mem_wraddr  (mem_wraddr),
        .mem_whilo   (mem_whilo),
        .mem_hilo    (mem_hilo),
        .wb          (wb_bus.src)
    );

    wb_load_align u_wb_load_align (
        .wb (wb_bus.dst),
        .cm (cm_bus.src)
    );

    reg_file_hilo u_reg_file_hilo (
        .clk     (clk),
        .rst     (rst),
        .cm      (cm_bus.dst),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .hi      (hi),
        .lo      (lo)
    );

    assign wb_pc = wb_bus.pc;

endmodule

// File: tb_mem_wb.sv
// Directed testbench for the MEM/WB writeback back end; run through project.f and the Makefile.
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_mem_wb;
    import cpu_types_pkg::*;
    import alu_op_pkg::*;

    logic      clk;
    logic      rst;
    logic      stall;
    logic      flush;
    addr_t     mem_pc;
    alu_op_t   mem_aluop;
    word_t     mem_alures;
    word_t     mem_opr2;
    addr_t     mem_m_vaddr;
    word_t     mem_m_rdata;
    logic      mem_wreg;
    reg_addr_t mem_wraddr;
    logic      mem_whilo;
    dword_t    mem_hilo;
    addr_t     wb_pc;
    reg_addr_t rd_addr;
    word_t     rd_data;
    word_t     hi;
    word_t     lo;

    integer seed;
    int     rise_count = 0;
    int     errors = 0;
    int     tests_pass = 0;
    int     tests_fail = 0;
    // expected architectural registers.
    word_t  exp_rf [`REG_NUM];

    mem_wb_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) rise_count <= rise_count + 1;

    // waits on falling edges until n rising edges have passed.
    task automatic wait_rises(input int n);
        int target;
        int guard;
        target = rise_count + n;
        guard = 0;
        while (rise_count < target && guard < 4 * n + 4) begin
            @(negedge clk);
            guard++;
        end
        if (rise_count < target) begin
            $display("timeout: %0d rising clock edges did not arrive", n);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic drive_rec(input addr_t pc, input alu_op_t op, input word_t res,
                             input word_t o2, input addr_t va, input word_t rd,
                             input logic we, input reg_addr_t wa, input logic wh,
                             input dword_t hl);
        mem_pc      = pc;
        mem_aluop   = op;
        mem_alures  = res;
        mem_opr2    = o2;
        mem_m_vaddr = va;
        mem_m_rdata = rd;
        mem_wreg    = we;
        mem_wraddr  = wa;
        mem_whilo   = wh;
        mem_hilo    = hl;
    endtask

    task automatic put_idle();
        drive_rec('0, ALU_NOP, '0, '0, '0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input reg_addr_t a);
        rd_addr = a;
        #1;
        check_eq($sformatf("rd_data[r%0d]", a), rd_data, exp_rf[a]);
    endtask

    task automatic end_test(input string name, input int e0);
        if (errors == e0) begin
            $display("test %s: ok", name);
            tests_pass++;
        end else begin
            $display("test %s: %0d check(s) wrong", name, errors - e0);
            tests_fail++;
        end
    endtask

    // little-endian load rules built byte by byte.
    function automatic word_t exp_load(input alu_op_t op, input int o, input word_t mem,
                                       input word_t old);
        word_t       r;
        logic [7:0]  b;
        logic [15:0] h;
        b = mem[8*o +: 8];
        h = mem[8*(o & 2) +: 16];
        r = old;
        case (op)
            ALU_LB:  r = {{24{b[7]}}, b};
            ALU_LBU: r = {24'h0, b};
            ALU_LH:  r = {{16{h[15]}}, h};
            ALU_LHU: r = {16'h0, h};
            ALU_LW:  r = mem;
            // upper register bytes take memory bytes o down to 0.
            ALU_LWL: for (int k = 0; k <= o; k++) r[8*(3-o+k) +: 8] = mem[8*k +: 8];
            ALU_LWR: for (int k = 0; k <= 3 - o; k++) r[8*k +: 8] = mem[8*(o+k) +: 8];
            default: r = old;
        endcase
        return r;
    endfunction

    task automatic commit_alu(input addr_t pc, input reg_addr_t r, input word_t v);
        wait_rises(1);
        stall = 1'b0;
        flush = 1'b0;
        drive_rec(pc, ALU_ADD, v, '0, '0, '0, 1'b1, r, 1'b0, '0);
        wait_rises(2);
        if (r != '0) exp_rf[r] = v;
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_eq("wb_pc", wb_pc, '0);
        check_eq("hi", hi, '0);
        check_eq("lo", lo, '0);
        for (int i = 0; i < `REG_NUM; i++) check_reg(reg_addr_t'(i));
        end_test("reset", e0);
    endtask

    task automatic test_alu_write();
        int        e0;
        reg_addr_t r;
        word_t     v;
        e0 = errors;
        r = reg_addr_t'(1 + ($unsigned($random(seed)) % 31));
        v = $random(seed);
        commit_alu(32'h0040_0010, r, v);
        check_reg(r);
        check_eq("wb_pc", wb_pc, 32'h0040_0010);
        commit_alu(32'h0040_0014, 5'd0, ~v);
        check_reg(5'd0);
        // store with wreg low.
        wait_rises(1);
        drive_rec(32'h0040_0018, ALU_SW, ~v, v, 32'h1000_0000, '0, 1'b0, r, 1'b0, '0);
        wait_rises(2);
        check_reg(r);
        end_test("alu_write", e0);
    endtask

    task automatic test_loads();
        int      e0;
        int      step;
        word_t   d;
        word_t   o2;
        alu_op_t op;
        alu_op_t ops [7];
        e0 = errors;
        ops = '{ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR};
        foreach (ops[i]) begin
            op = ops[i];
            step = (op == ALU_LH || op == ALU_LHU) ? 2 : (op == ALU_LW) ? 4 : 1;
            for (int o = 0; o < 4; o += step) begin
                d = $random(seed);
                o2 = $random(seed);
                wait_rises(1);
                drive_rec(32'h0040_0100, op, 32'hdead_beef, o2, 32'h1000_0000 + o, d,
                          1'b1, 5'd7, 1'b0, '0);
                wait_rises(2);
                exp_rf[7] = exp_load(op, o, d, o2);
                rd_addr = 5'd7;
                #1;
                check_eq($sformatf("rd_data (op %h, offset %0d)", op, o), rd_data, exp_rf[7]);
            end
        end
        end_test("loads", e0);
    endtask

    task automatic test_hilo();
        int    e0;
        word_t hv;
        word_t lv;
        e0 = errors;
        hv = $random(seed);
        lv = $random(seed);
        wait_rises(1);
        drive_rec(32'h0040_0200, ALU_ADD, hv ^ lv, '0, '0, '0, 1'b0, 5'd7, 1'b1, {hv, lv});
        wait_rises(2);
        check_eq("hi", hi, hv);
        check_eq("lo", lo, lv);
        for (int i = 0; i < `REG_NUM; i++) check_reg(reg_addr_t'(i));
        end_test("hilo", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        commit_alu(32'h0040_0300, 5'd9, $random(seed));
        // stall alone would hold the record above.
        wait_rises(1);
        flush = 1'b1;
        stall = 1'b1;
        drive_rec(32'h0040_0304, ALU_ADD, 32'hffff_0000, '0, '0, '0, 1'b1, 5'd9, 1'b0, '0);
        wait_rises(2);
        check_reg(5'd9);
        check_eq("wb_pc", wb_pc, '0);
        commit_alu(32'h0040_0308, 5'd9, $random(seed));
        wait_rises(1);
        flush = 1'b1;
        drive_rec(32'h0040_030c, ALU_ADD, 32'h0000_ffff, '0, '0, '0, 1'b1, 5'd9, 1'b0, '0);
        wait_rises(2);
        check_reg(5'd9);
        check_eq("wb_pc", wb_pc, '0);
        wait_rises(1);
        flush = 1'b0;
        put_idle();
        end_test("flush", e0);
    endtask

    task automatic test_stall();
        int    e0;
        word_t vb;
        e0 = errors;
        vb = $random(seed);
        commit_alu(32'h0040_0400, 5'd12, $random(seed));
        wait_rises(1);
        stall = 1'b1;
        drive_rec(32'h0040_0404, ALU_ADD, vb, '0, '0, '0, 1'b1, 5'd12, 1'b0, '0);
        wait_rises(2);
        check_eq("wb_pc", wb_pc, 32'h0040_0400);
        check_reg(5'd12);
        wait_rises(1);
        stall = 1'b0;
        wait_rises(2);
        exp_rf[12] = vb;
        check_eq("wb_pc", wb_pc, 32'h0040_0404);
        check_reg(5'd12);
        end_test("stall", e0);
    endtask

    initial begin
        seed = 97;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        rd_addr = '0;
        foreach (exp_rf[i]) exp_rf[i] = '0;
        put_idle();
        wait_rises(10);
        rst = 1'b0;
        test_reset();
        test_alu_write();
        test_loads();
        test_hilo();
        test_flush();
        test_stall();
        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
cpu_types_pkg.sv
alu_op_pkg.sv
wb_if.sv
mem_wb_reg.sv
wb_load_align.sv
reg_file_hilo.sv
mem_wb_top.sv
tb_mem_wb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST)) mips_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
